//--- source/vmode_pkg.sv
package vmode_pkg;

	// ============================================================
	// Frame geometry and memory sizes
	// ============================================================
	localparam int FRAME_WIDTH = 320;
	localparam int FRAME_HEIGHT = 240;
	localparam int PIXEL_PITCH = 320;
	localparam int VRAM_WORDS = 19200;
	localparam int PALETTE_ENTRIES = 256;

	localparam int VRAM_ADDR_W = $clog2(VRAM_WORDS);
	localparam int FB_BYTE_W = VRAM_ADDR_W + 2;
	localparam int X_W = $clog2(FRAME_WIDTH);
	localparam int Y_W = $clog2(FRAME_HEIGHT);

	// ============================================================
	// Address map and flow control
	// ============================================================
	localparam logic [31:0] PALETTE_BASE = 32'h0100_0000;
	localparam int PIXEL_CREDITS = 8;
	localparam int CREDIT_W = $clog2(PIXEL_CREDITS + 1);

	typedef logic [31:0] word_t;
	typedef logic [23:0] rgb_t;
	typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
	typedef logic [7:0] palette_index_t;

	typedef struct packed {
		logic request;
		logic rw;
		logic [31:0] address;
		word_t wdata;
	} cpu_request_t;

	typedef struct packed {
		logic ready;
		word_t rdata;
	} cpu_response_t;

	// One RAM port, palette uses the low address bits
	typedef struct packed {
		logic request;
		logic rw;
		vram_addr_t address;
		word_t wdata;
	} ram_port_t;

	typedef struct packed {
		logic valid;
		rgb_t rgb;
		logic last_in_line;
		logic last_in_frame;
	} pixel_t;

endpackage

//--- source/bram_dual.sv
`timescale 1ns/1ps

module bram_dual import vmode_pkg::*; #(
	parameter type payload_t = word_t,
	parameter int DEPTH = VRAM_WORDS
)(
	input i_clock,

	input ram_port_t i_port_a,
	output payload_t o_rdata_a,

	input ram_port_t i_port_b,
	output payload_t o_rdata_b
);

	// Storage rounds up to a power of two so every address pattern decodes
	payload_t memory [0:(2**$clog2(DEPTH))-1];

	logic [$clog2(DEPTH)-1:0] address_a;
	logic [$clog2(DEPTH)-1:0] address_b;

	assign address_a = i_port_a.address[$clog2(DEPTH)-1:0];
	assign address_b = i_port_b.address[$clog2(DEPTH)-1:0];

	// Both ports in one process, port B wins a write collision
	always_ff @(posedge i_clock) begin
		if (i_port_a.request) begin
			if (i_port_a.rw) begin
				memory[address_a] <= payload_t'(i_port_a.wdata[$bits(payload_t)-1:0]);
			end else begin
				o_rdata_a <= memory[address_a];
			end
		end

		if (i_port_b.request) begin
			if (i_port_b.rw) begin
				memory[address_b] <= payload_t'(i_port_b.wdata[$bits(payload_t)-1:0]);
			end else begin
				o_rdata_b <= memory[address_b];
			end
		end
	end

endmodule

//--- source/cpu_port_decoder.sv
`timescale 1ns/1ps

module cpu_port_decoder import vmode_pkg::*; (
	input i_clock,
	input i_reset,

	input cpu_request_t i_cpu,
	output cpu_response_t o_cpu,

	output ram_port_t o_vram_port,
	input word_t i_vram_rdata,

	output ram_port_t o_palette_port
);

	logic is_palette;
	logic issue;
	logic pending;
	logic pending_palette;
	word_t palette_offset;
	palette_index_t palette_index;

	assign is_palette = (i_cpu.address >= PALETTE_BASE);
	assign palette_offset = i_cpu.address - PALETTE_BASE;
	assign palette_index = palette_offset[9:2];

	// A held request goes out only once
	assign issue = i_cpu.request && !pending;

	always_comb begin
		o_vram_port.request = issue && !is_palette;
		o_vram_port.rw = i_cpu.rw;
		o_vram_port.address = i_cpu.address[2 +: VRAM_ADDR_W];
		o_vram_port.wdata = i_cpu.wdata;

		// Palette port is write only
		o_palette_port.request = issue && is_palette && i_cpu.rw;
		o_palette_port.rw = 1'b1;
		o_palette_port.address = vram_addr_t'(palette_index);
		o_palette_port.wdata = i_cpu.wdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pending <= 1'b0;
		end else begin
			pending <= issue;
		end
	end

	always_ff @(posedge i_clock) begin
		if (issue) begin
			pending_palette <= is_palette;
		end
	end

	// Answer lines up with the RAM read latency
	assign o_cpu.ready = pending;
	assign o_cpu.rdata = pending_palette ? '0 : i_vram_rdata;

endmodule

//--- source/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch import vmode_pkg::*; (
	input i_clock,
	input i_reset,

	input i_frame_start,
	input i_credit_return,

	output ram_port_t o_vram_port,

	output logic o_word_load,
	output logic o_issue,
	output logic o_last_in_line,
	output logic o_last_in_frame
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_LOAD,
		ST_ISSUE
	} state_t;

	state_t state;
	logic [X_W-1:0] x;
	logic [Y_W-1:0] y;
	logic [1:0] issue_count;
	logic [CREDIT_W-1:0] credits;
	logic [FB_BYTE_W-1:0] byte_address;

	// ============================================================
	// Raster position and word address
	// ============================================================
	assign byte_address = FB_BYTE_W'(y * PIXEL_PITCH) + FB_BYTE_W'(x);

	assign o_last_in_line = (x == X_W'(FRAME_WIDTH - 1));
	assign o_last_in_frame = o_last_in_line && (y == Y_W'(FRAME_HEIGHT - 1));

	always_comb begin
		o_vram_port.request = (state == ST_READ);
		o_vram_port.rw = 1'b0;
		o_vram_port.address = byte_address[FB_BYTE_W-1:2];
		o_vram_port.wdata = '0;
	end

	// Word arrives the cycle after the read
	assign o_word_load = (state == ST_LOAD);

	// Every issue costs one credit
	assign o_issue = (state == ST_ISSUE) && (credits != '0);

	// ============================================================
	// Fetch state machine
	// ============================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			x <= '0;
			y <= '0;
			issue_count <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Frame start is ignored while a frame runs
					if (i_frame_start) begin
						x <= '0;
						y <= '0;
						issue_count <= '0;
						state <= ST_READ;
					end
				end

				ST_READ: begin
					state <= ST_LOAD;
				end

				ST_LOAD: begin
					state <= ST_ISSUE;
				end

				ST_ISSUE: begin
					if (o_issue) begin
						issue_count <= issue_count + 2'd1;
						if (o_last_in_line) begin
							x <= '0;
							y <= y + Y_W'(1);
						end else begin
							x <= x + X_W'(1);
						end

						if (o_last_in_frame) begin
							state <= ST_IDLE;
						end else if (issue_count == 2'd3) begin
							state <= ST_READ;
						end
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Credit counter
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			credits <= CREDIT_W'(PIXEL_CREDITS);
		end else begin
			credits <= credits - CREDIT_W'(o_issue) + CREDIT_W'(i_credit_return);
		end
	end

endmodule

//--- source/palette_expander.sv
`timescale 1ns/1ps

module palette_expander import vmode_pkg::*; (
	input i_clock,
	input i_reset,

	input i_word_load,
	input word_t i_vram_rdata,

	input i_issue,
	input i_last_in_line,
	input i_last_in_frame,

	output ram_port_t o_palette_port,
	input rgb_t i_palette_rdata,

	output pixel_t o_pixel
);

	word_t word_q;
	logic [1:0] byte_ptr;
	palette_index_t index;
	logic valid_q;
	logic line_q;
	logic frame_q;

	always_ff @(posedge i_clock) begin
		if (i_word_load) begin
			word_q <= i_vram_rdata;
		end
	end

	// Low byte goes out first
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			byte_ptr <= '0;
		end else if (i_word_load) begin
			byte_ptr <= '0;
		end else if (i_issue) begin
			byte_ptr <= byte_ptr + 2'd1;
		end
	end

	assign index = word_q[{byte_ptr, 3'b000} +: 8];

	always_comb begin
		o_palette_port.request = i_issue;
		o_palette_port.rw = 1'b0;
		o_palette_port.address = vram_addr_t'(index);
		o_palette_port.wdata = '0;
	end

	// ============================================================
	// Flags follow the colour through the palette read
	// ============================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_issue;
		end
	end

	always_ff @(posedge i_clock) begin
		line_q <= i_last_in_line;
		frame_q <= i_last_in_frame;
	end

	always_comb begin
		o_pixel.valid = valid_q;
		o_pixel.rgb = i_palette_rdata;
		o_pixel.last_in_line = line_q;
		o_pixel.last_in_frame = frame_q;
	end

endmodule

//--- source/vmode_chunky_top.sv
`timescale 1ns/1ps

module vmode_chunky_top import vmode_pkg::*; (
	input i_clock,
	input i_reset,

	// CPU
	input cpu_request_t i_cpu,
	output cpu_response_t o_cpu,

	// Video
	input i_frame_start,
	input i_credit_return,
	output pixel_t o_pixel
);

	ram_port_t vram_port_a;
	ram_port_t vram_port_b;
	word_t vram_rdata_a;
	word_t vram_rdata_b;

	ram_port_t palette_port_a;
	ram_port_t palette_port_b;
	rgb_t palette_rdata_b;

	logic word_load;
	logic issue;
	logic last_in_line;
	logic last_in_frame;

	// ============================================================
	// CPU side
	// ============================================================
	cpu_port_decoder decoder (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_cpu(i_cpu),
		.o_cpu(o_cpu),
		.o_vram_port(vram_port_a),
		.i_vram_rdata(vram_rdata_a),
		.o_palette_port(palette_port_a)
	);

	bram_dual #(
		.payload_t(word_t),
		.DEPTH(VRAM_WORDS)
	) vram (
		.i_clock(i_clock),
		.i_port_a(vram_port_a),
		.o_rdata_a(vram_rdata_a),
		.i_port_b(vram_port_b),
		.o_rdata_b(vram_rdata_b)
	);

	// Port A only writes
	bram_dual #(
		.payload_t(rgb_t),
		.DEPTH(PALETTE_ENTRIES)
	) palette (
		.i_clock(i_clock),
		.i_port_a(palette_port_a),
		.o_rdata_a(),
		.i_port_b(palette_port_b),
		.o_rdata_b(palette_rdata_b)
	);

	// ============================================================
	// Video side
	// ============================================================
	pixel_fetch fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_frame_start(i_frame_start),
		.i_credit_return(i_credit_return),
		.o_vram_port(vram_port_b),
		.o_word_load(word_load),
		.o_issue(issue),
		.o_last_in_line(last_in_line),
		.o_last_in_frame(last_in_frame)
	);

	palette_expander expander (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_word_load(word_load),
		.i_vram_rdata(vram_rdata_b),
		.i_issue(issue),
		.i_last_in_line(last_in_line),
		.i_last_in_frame(last_in_frame),
		.o_palette_port(palette_port_b),
		.i_palette_rdata(palette_rdata_b),
		.o_pixel(o_pixel)
	);

endmodule

//--- tests/vmode_tb_clock.sv
`timescale 1ns/1ps

module vmode_tb_clock #(
	parameter int HALF_PERIOD = 2,
	parameter int RESET_CYCLES = 5
)(
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever begin
			#HALF_PERIOD o_clock = ~o_clock;
		end
	end

	// Released on the edge so the DUT sees exactly RESET_CYCLES edges
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

//--- tests/vmode_assertions.sv
`timescale 1ns/1ps

module vmode_assertions import vmode_pkg::*; (
	input i_clock,
	input i_reset,
	input i_issue,
	input i_credit_return,
	input i_cpu_request,
	input i_cpu_ready
);

	int outstanding;

	// Pixels issued and not yet paid back by the consumer
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(i_issue) - int'(i_credit_return);
		end
	end

	// ============================================================
	// Credit protocol
	// ============================================================
	credit_range: assert property (@(posedge i_clock) disable iff (i_reset)
		(outstanding >= 0) && (outstanding <= PIXEL_CREDITS))
		else $error("unreturned pixel count %0d out of range", outstanding);

	// Pixel valid is this strobe one cycle later
	quiet_in_reset: assert property (@(posedge i_clock)
		i_reset |=> !i_issue)
		else $error("pixel issued during reset");

	// ============================================================
	// CPU response timing
	// ============================================================
	ready_after_request: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(i_cpu_request) |=> i_cpu_ready)
		else $error("CPU ready missing one cycle after request");

	ready_one_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
		i_cpu_ready |=> !i_cpu_ready)
		else $error("CPU ready longer than one cycle");

endmodule

//--- tests/vmode_tb.sv
`timescale 1ns/1ps

module vmode_tb import vmode_pkg::*; ();

	localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int CPU_TIMEOUT = 16;
	localparam int FRAME_TIMEOUT = FRAME_PIXELS * 8;
	localparam logic [31:0] LFSR_SEED = 32'd68542;

	logic clock;
	logic reset;
	cpu_request_t cpu;
	cpu_response_t response;
	logic frame_start;
	logic credit_return;
	pixel_t pixel;

	// Reference models
	word_t fb_model [0:VRAM_WORDS-1];
	rgb_t palette_model [0:PALETTE_ENTRIES-1];

	logic [31:0] data_lfsr;
	logic [31:0] delay_lfsr;
	int error_count;
	int check_count;
	int test_count;
	event timeout_seen;

	// Consumer state
	logic frame_active;
	logic hold_credits;
	logic random_delays;
	int pixel_count;
	int owed_credits;
	int credit_delay;

	vmode_tb_clock clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	vmode_chunky_top UUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_cpu(cpu),
		.o_cpu(response),
		.i_frame_start(frame_start),
		.i_credit_return(credit_return),
		.o_pixel(pixel)
	);

	bind pixel_fetch vmode_assertions fetch_checks (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_issue(o_issue),
		.i_credit_return(i_credit_return),
		.i_cpu_request(1'b0),
		.i_cpu_ready(1'b0)
	);

	bind cpu_port_decoder vmode_assertions decoder_checks (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_issue(1'b0),
		.i_credit_return(1'b0),
		.i_cpu_request(i_cpu.request),
		.i_cpu_ready(o_cpu.ready)
	);

	// ============================================================
	// Helpers
	// ============================================================
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] random_bits(inout logic [31:0] state, input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			state = lfsr_next(state);
			value = {value[30:0], state[0]};
		end
		return value;
	endfunction

	function automatic pixel_t expected_pixel(input int index);
		int x;
		int y;
		int byte_address;
		word_t word;
		palette_index_t entry;
		pixel_t result;
		x = index % FRAME_WIDTH;
		y = index / FRAME_WIDTH;
		byte_address = y * PIXEL_PITCH + x;
		word = fb_model[vram_addr_t'(byte_address / 4)];
		entry = palette_index_t'(word >> (8 * (byte_address % 4)));
		result.valid = 1'b1;
		result.rgb = palette_model[entry];
		result.last_in_line = (x == FRAME_WIDTH - 1);
		result.last_in_frame = (index == FRAME_PIXELS - 1);
		return result;
	endfunction

	task automatic report_error(input string message);
		error_count++;
		$display("[FAIL] %0t ns: %s", $time, message);
	endtask

	task automatic compare_word(input word_t actual, input word_t expected, input string what);
		check_count++;
		if (actual !== expected) begin
			report_error($sformatf("%s: got %h, expected %h", what, actual, expected));
		end
	endtask

	task automatic compare_pixel(input pixel_t actual, input pixel_t expected, input string what);
		check_count++;
		if (actual !== expected) begin
			report_error($sformatf("%s: got rgb %h line %b frame %b, expected rgb %h line %b frame %b",
				what, actual.rgb, actual.last_in_line, actual.last_in_frame,
				expected.rgb, expected.last_in_line, expected.last_in_frame));
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: gave up waiting for %s", what);
		-> timeout_seen;
	endtask

	// Any expired wait ends the run
	initial begin
		@(timeout_seen);
		$display("sim failed");
		$finish;
	end

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		$display("%0t ns: test %s finished with %0d errors", $time, name,
			error_count - errors_before);
	endtask

	task automatic cpu_access(input logic rw, input logic [31:0] address, input word_t wdata,
		output word_t rdata);
		int waited;
		cpu.request = 1'b1;
		cpu.rw = rw;
		cpu.address = address;
		cpu.wdata = wdata;
		waited = 0;
		do begin
			@(posedge clock);
			#1;
			waited++;
		end while (!response.ready && waited < CPU_TIMEOUT);
		if (!response.ready) begin
			report_timeout($sformatf("CPU ready at address %h", address));
		end
		compare_word(word_t'(waited), 32'd1, $sformatf("ready latency at %h", address));
		rdata = response.rdata;
		cpu.request = 1'b0;
		@(posedge clock);
		#1;
	endtask

	task automatic start_frame();
		pixel_count = 0;
		frame_active = 1'b1;
		frame_start = 1'b1;
		@(posedge clock);
		#1;
		frame_start = 1'b0;
	endtask

	task automatic wait_frame_done(input string what);
		int waited;
		waited = 0;
		while (frame_active && waited < FRAME_TIMEOUT) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (frame_active) begin
			report_timeout(what);
		end
	endtask

	task automatic take_pixel();
		owed_credits++;
		if (owed_credits > PIXEL_CREDITS) begin
			report_error($sformatf("%0d unreturned pixels, limit %0d", owed_credits, PIXEL_CREDITS));
		end
		if (!frame_active) begin
			report_error("valid pixel outside a frame");
		end else begin
			compare_pixel(pixel, expected_pixel(pixel_count), $sformatf("pixel %0d", pixel_count));
			pixel_count++;
			if (pixel_count == FRAME_PIXELS) begin
				frame_active = 1'b0;
			end
		end
	endtask

	// Display consumer, one credit back per accepted pixel
	initial begin
		credit_return = 1'b0;
		owed_credits = 0;
		credit_delay = 0;
		delay_lfsr = LFSR_SEED;
		forever begin
			@(posedge clock);
			#1;
			if (pixel.valid) begin
				take_pixel();
			end
			credit_return = 1'b0;
			if (credit_delay > 0) begin
				credit_delay--;
			end else if (owed_credits > 0 && !hold_credits) begin
				credit_return = 1'b1;
				owed_credits--;
				if (random_delays) begin
					credit_delay = int'(random_bits(delay_lfsr, 2));
				end
			end
		end
	end

	// ============================================================
	// Tests
	// ============================================================
	task automatic test_reset_state();
		int errors_before;
		errors_before = error_count;
		repeat (16) begin
			compare_word(word_t'(response.ready), '0, "CPU ready after reset");
			compare_word(word_t'(pixel.valid), '0, "pixel valid after reset");
			@(posedge clock);
			#1;
		end
		finish_test("reset_state", errors_before);
	endtask

	task automatic test_framebuffer_access();
		int errors_before;
		logic [31:0] addresses [$];
		word_t written [$];
		word_t rdata;
		errors_before = error_count;
		addresses = '{32'h0000_0000, 32'h0000_0004, 32'h0000_1230, 32'h0001_2BFC, 32'h00FF_FFFC};
		for (int i = 0; i < addresses.size(); i++) begin
			written.push_back(random_bits(data_lfsr, 32));
			cpu_access(1'b1, addresses[i], written[i], rdata);
		end
		for (int i = 0; i < addresses.size(); i++) begin
			cpu_access(1'b0, addresses[i], '0, rdata);
			compare_word(rdata, written[i], $sformatf("read back %h", addresses[i]));
		end
		finish_test("framebuffer_access", errors_before);
	endtask

	task automatic test_pixel_stream();
		int errors_before;
		word_t data;
		word_t rdata;
		errors_before = error_count;
		for (int i = 0; i < VRAM_WORDS; i++) begin
			data = random_bits(data_lfsr, 32);
			fb_model[vram_addr_t'(i)] = data;
			cpu_access(1'b1, 32'(i) << 2, data, rdata);
		end
		for (int i = 0; i < PALETTE_ENTRIES; i++) begin
			data = random_bits(data_lfsr, 32);
			palette_model[palette_index_t'(i)] = rgb_t'(data);
			cpu_access(1'b1, PALETTE_BASE + (32'(i) << 2), data, rdata);
		end
		start_frame();
		wait_frame_done("frame with immediate credits");
		finish_test("pixel_stream", errors_before);
	endtask

	task automatic test_palette_access();
		int errors_before;
		palette_index_t entries [$];
		word_t data;
		word_t rdata;
		errors_before = error_count;
		// Entry 0 sits at PALETTE_BASE, the rest feed the first four pixels
		entries.push_back(8'd0);
		for (int i = 0; i < 4; i++) begin
			entries.push_back(palette_index_t'(fb_model[0] >> (8 * i)));
		end
		for (int i = 0; i < entries.size(); i++) begin
			data = random_bits(data_lfsr, 32);
			palette_model[entries[i]] = rgb_t'(data);
			cpu_access(1'b1, PALETTE_BASE + (32'(entries[i]) << 2), data, rdata);
		end
		cpu_access(1'b0, PALETTE_BASE + 32'h10, '0, rdata);
		compare_word(rdata, '0, "palette read data");
		cpu_access(1'b0, 32'h0, '0, rdata);
		compare_word(rdata, fb_model[0], "frame buffer word 0 after palette writes");
		start_frame();
		wait_frame_done("frame after palette writes");
		finish_test("palette_access", errors_before);
	endtask

	task automatic test_back_pressure();
		int errors_before;
		int waited;
		errors_before = error_count;
		hold_credits = 1'b1;
		start_frame();
		waited = 0;
		while (pixel_count < PIXEL_CREDITS && waited < 100) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (pixel_count < PIXEL_CREDITS) begin
			report_timeout("first pixels with credits withheld");
		end
		repeat (200) begin
			@(posedge clock);
			#1;
		end
		compare_word(word_t'(pixel_count), word_t'(PIXEL_CREDITS), "pixels while credits withheld");
		random_delays = 1'b1;
		hold_credits = 1'b0;
		wait_frame_done("frame with delayed credits");
		random_delays = 1'b0;
		finish_test("back_pressure", errors_before);
	endtask

	task automatic test_frame_end();
		int errors_before;
		int waited;
		errors_before = error_count;
		start_frame();
		waited = 0;
		while (pixel_count < FRAME_WIDTH && waited < FRAME_TIMEOUT) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (pixel_count < FRAME_WIDTH) begin
			report_timeout("first line of the frame");
		end
		// A second start inside the frame must not restart it
		frame_start = 1'b1;
		@(posedge clock);
		#1;
		frame_start = 1'b0;
		wait_frame_done("end of frame");
		// Stream stays quiet once the last pixel is out
		repeat (64) begin
			@(posedge clock);
			#1;
			compare_word(word_t'(pixel.valid), '0, "pixel valid after frame end");
		end
		finish_test("frame_end", errors_before);
	endtask

	initial begin
		int waited;
		cpu = '0;
		frame_start = 1'b0;
		frame_active = 1'b0;
		hold_credits = 1'b0;
		random_delays = 1'b0;
		pixel_count = 0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		data_lfsr = LFSR_SEED;
		waited = 0;
		while (reset !== 1'b0 && waited < 20) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (reset !== 1'b0) begin
			report_timeout("reset release");
		end
		test_reset_state();
		test_framebuffer_access();
		test_pixel_stream();
		test_palette_access();
		test_back_pressure();
		test_frame_end();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- build.f
source/vmode_pkg.sv
source/bram_dual.sv
source/cpu_port_decoder.sv
source/pixel_fetch.sv
source/palette_expander.sv
source/vmode_chunky_top.sv
tests/vmode_tb_clock.sv
tests/vmode_assertions.sv
tests/vmode_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = vmode_tb
FILE_LIST = build.f
BUILD_DIR = obj_dir
LOG = sim.log
BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "test run FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
